//--- filelist.f
regex_pkg.sv
regex_fetch.sv
regex_execute.sv
regex_pc_merge.sv
regex_cpu.sv
tb_regex_cpu.sv

//--- Bender.yml
package:
  name: regex_cpu

sources:
  - regex_pkg.sv
  - regex_fetch.sv
  - regex_execute.sv
  - regex_pc_merge.sv
  - regex_cpu.sv
  - target: test
    files:
      - tb_regex_cpu.sv

//--- tb_regex_cpu.sv
// self-checking testbench for regex_cpu with an instruction memory model, a reference model and output checks
`timescale 1ns/1ps

module tb_regex_cpu;

    localparam int RESET_CYCLES = 8;
    localparam int SINGLE_REPS  = 8;
    localparam int STREAM_LEN   = 60;
    localparam int THREAD_COUNT = 10 * SINGLE_REPS + 2 * STREAM_LEN;
    localparam int CYCLE_LIMIT  = THREAD_COUNT * 20 + RESET_CYCLES;

    logic                               clk = 1'b0;
    logic                               rst;
    regex_pkg::window_t                 current_characters;
    logic [regex_pkg::WINDOW_CHARS-1:0] end_of_string;
    logic                               input_pc_valid;
    regex_pkg::pc_t                     input_pc;
    regex_pkg::cc_id_t                  input_cc_id;
    logic                               input_pc_ready;
    logic                               memory_ready;
    logic                               memory_valid;
    logic [regex_pkg::ADDR_WIDTH-1:0]   memory_addr;
    regex_pkg::instr_t                  memory_data;
    logic                               output_pc_valid;
    regex_pkg::pc_t                     output_pc;
    regex_pkg::cc_id_t                  output_cc_id;
    logic                               output_pc_ready;
    logic                               accepts;
    logic                               running;

    regex_pkg::instr_t mem [0:(1 << regex_pkg::PC_WIDTH) - 1];
    logic              req_fire;
    regex_pkg::pc_t    req_pc;
    regex_pkg::pc_t    exp_pc_q[$];
    regex_pkg::cc_id_t exp_cc_q[$];
    logic              in_order;
    logic              throttle;
    int                acc_count = 0;
    int                cycle_count = 0;
    logic              hold_check = 1'b0;
    regex_pkg::pc_t    held_pc;
    regex_pkg::cc_id_t held_cc_id;

    regex_cpu uut (.*);

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_pc(input string name, input regex_pkg::pc_t got,
                              input regex_pkg::pc_t exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_cc_id(input string name, input regex_pkg::cc_id_t got,
                                 input regex_pkg::cc_id_t exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_addr(input string name,
                                input logic [regex_pkg::ADDR_WIDTH-1:0] got,
                                input logic [regex_pkg::ADDR_WIDTH-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // accept flag and up to two continuation threads of one instruction
    function automatic void reference_model(
        input  regex_pkg::pc_t     pc,
        input  regex_pkg::cc_id_t  cc,
        input  regex_pkg::instr_t  instr,
        input  regex_pkg::window_t win,
        input  logic [3:0]         eos,
        output logic               acc,
        output int                 count,
        output regex_pkg::pc_t     pc_a,
        output regex_pkg::cc_id_t  cc_a,
        output regex_pkg::pc_t     pc_b,
        output regex_pkg::cc_id_t  cc_b
    );
        regex_pkg::char_t ch;
        regex_pkg::char_t lo;
        regex_pkg::char_t hi;
        ch    = regex_pkg::char_t'(win >> (8 * cc));
        lo    = instr.operand.chars.range_low;
        hi    = instr.operand.chars.range_high;
        acc   = 1'b0;
        count = 0;
        pc_a  = pc + 1'b1;
        cc_a  = cc + 1'b1;
        pc_b  = instr.operand.branch.target;
        cc_b  = cc;
        case (instr.opcode)
            regex_pkg::ACCEPT:          acc = eos[cc];
            regex_pkg::ACCEPT_PARTIAL:  acc = 1'b1;
            regex_pkg::SPLIT:
            begin
                count = 2;
                cc_a  = cc;
            end
            regex_pkg::MATCH:           count = (ch == hi);
            regex_pkg::NOT_MATCH:       count = (ch != hi);
            regex_pkg::MATCH_RANGE:     count = (ch >= lo && ch <= hi);
            regex_pkg::NOT_MATCH_RANGE: count = !(ch >= lo && ch <= hi);
            regex_pkg::MATCH_ANY:       count = 1;
            regex_pkg::JMP:
            begin
                count = 1;
                pc_a  = instr.operand.branch.target;
                cc_a  = cc;
            end
            default:                    count = 0;
        endcase
    endfunction

    task automatic expect_thread(input regex_pkg::pc_t pc, input regex_pkg::cc_id_t cc,
                                 output logic exp_acc);
        regex_pkg::pc_t    pc_a;
        regex_pkg::cc_id_t cc_a;
        regex_pkg::pc_t    pc_b;
        regex_pkg::cc_id_t cc_b;
        int                count;
        reference_model(pc, cc, mem[pc], current_characters, end_of_string,
                        exp_acc, count, pc_a, cc_a, pc_b, cc_b);
        if (count > 0)
        begin
            exp_pc_q.push_back(pc_a);
            exp_cc_q.push_back(cc_a);
        end
        if (count > 1)
        begin
            exp_pc_q.push_back(pc_b);
            exp_cc_q.push_back(cc_b);
        end
    endtask

    task automatic check_output(input regex_pkg::pc_t pc, input regex_pkg::cc_id_t cc);
        int idx;
        idx = -1;
        if (exp_pc_q.size() == 0)
            fail_run($sformatf("output thread pc 0x%h cc_id 0x%h arrived with none expected",
                               pc, cc));
        else if (in_order)
        begin
            compare_pc("output_pc", pc, exp_pc_q[0]);
            compare_cc_id("output_cc_id", cc, exp_cc_q[0]);
            idx = 0;
        end
        else
        begin
            foreach (exp_pc_q[i])
                if (idx < 0 && exp_pc_q[i] == pc && exp_cc_q[i] == cc)
                    idx = i;
            if (idx < 0)
                fail_run($sformatf("[ERROR] output_pc 0x%h output_cc_id 0x%h not expected",
                                   pc, cc));
        end
        if (idx >= 0)
        begin
            exp_pc_q.delete(idx);
            exp_cc_q.delete(idx);
        end
    endtask

    // memory word shows up in the cycle after the accepted request
    always @(posedge clk)
    begin
        if (memory_valid && memory_ready)
            compare_addr("memory_addr", memory_addr, input_pc);
        req_fire <= memory_valid && memory_ready;
        req_pc   <= regex_pkg::pc_t'(memory_addr);
    end

    always @(negedge clk)
    begin
        if (req_fire)
            memory_data <= mem[req_pc];
        memory_ready    <= throttle ? 1'($urandom_range(1)) : 1'b1;
        output_pc_ready <= throttle ? 1'($urandom_range(1)) : 1'b1;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            fail_run($sformatf("timeout after %0d cycles, the DUT stopped making progress",
                               cycle_count));
    end

    // output monitor for accept pulses, stability under back-pressure and thread compare
    always @(posedge clk)
    begin
        if (!rst && accepts)
            acc_count = acc_count + 1;
        if (!rst && hold_check)
        begin
            compare_flag("output_pc_valid", output_pc_valid, 1'b1);
            compare_pc("output_pc", output_pc, held_pc);
            compare_cc_id("output_cc_id", output_cc_id, held_cc_id);
        end
        hold_check = !rst && output_pc_valid && !output_pc_ready;
        held_pc    = output_pc;
        held_cc_id = output_cc_id;
        if (!rst && output_pc_valid && output_pc_ready)
            check_output(output_pc, output_cc_id);
    end

    task automatic check_idle_outputs();
        compare_flag("output_pc_valid", output_pc_valid, 1'b0);
        compare_flag("memory_valid", memory_valid, 1'b0);
        compare_flag("input_pc_ready", input_pc_ready, 1'b0);
        compare_flag("accepts", accepts, 1'b0);
        compare_flag("running", running, 1'b0);
    endtask

    // called on a falling edge and returns on the falling edge after the thread is taken
    task automatic issue_thread(input regex_pkg::pc_t pc, input regex_pkg::cc_id_t cc);
        input_pc_valid = 1'b1;
        input_pc       = pc;
        input_cc_id    = cc;
        do
            @(posedge clk);
        while (!input_pc_ready);
        @(negedge clk);
    endtask

    task automatic wait_idle();
        input_pc_valid = 1'b0;
        do
            @(posedge clk);
        while (running);
        @(negedge clk);
        if (exp_pc_q.size() != 0)
            fail_run($sformatf("running dropped with %0d expected threads never seen",
                               exp_pc_q.size()));
    endtask

    task automatic run_single(input regex_pkg::opcode_t op, input int rep);
        regex_pkg::pc_t    pc;
        regex_pkg::cc_id_t cc;
        regex_pkg::char_t  ch;
        regex_pkg::instr_t instr;
        logic              exp_acc;
        pc                 = regex_pkg::pc_t'($urandom);
        cc                 = regex_pkg::cc_id_t'(rep);
        current_characters = $urandom;
        end_of_string      = 4'($urandom);
        ch                 = regex_pkg::char_t'(current_characters >> (8 * cc));
        instr.opcode       = op;
        instr.operand      = 16'($urandom);
        // half the passes steer the operand or end flag toward a hit
        if (op == regex_pkg::ACCEPT)
            end_of_string[cc] = rep[2];
        else if (rep[2])
        begin
            instr.operand.chars.range_high = ch;
            instr.operand.chars.range_low  = regex_pkg::char_t'($urandom_range(ch));
        end
        mem[pc]   = instr;
        in_order  = 1'b1;
        acc_count = 0;
        expect_thread(pc, cc, exp_acc);
        issue_thread(pc, cc);
        wait_idle();
        compare_flag("accepts", acc_count != 0, exp_acc);
        if (acc_count > 1)
            fail_run($sformatf("accepts stayed high for %0d cycles", acc_count));
    endtask

    task automatic run_stream(input logic with_backpressure);
        regex_pkg::pc_t    pc;
        regex_pkg::cc_id_t cc;
        logic              exp_acc;
        int                exp_accepts;
        throttle           = with_backpressure;
        in_order           = 1'b0;
        current_characters = $urandom;
        end_of_string      = 4'($urandom);
        foreach (mem[i])
        begin
            mem[i].opcode  = regex_pkg::opcode_t'($urandom_range(9));
            mem[i].operand = 16'($urandom);
        end
        acc_count   = 0;
        exp_accepts = 0;
        repeat (STREAM_LEN)
        begin
            pc = regex_pkg::pc_t'($urandom);
            cc = regex_pkg::cc_id_t'($urandom);
            expect_thread(pc, cc, exp_acc);
            exp_accepts = exp_accepts + exp_acc;
            issue_thread(pc, cc);
        end
        wait_idle();
        throttle = 1'b0;
        if (acc_count != exp_accepts)
            fail_run($sformatf("[ERROR] accepts pulse count 0x%h expected 0x%h",
                               acc_count, exp_accepts));
    endtask

    initial
    begin
        void'($urandom(32'h3034));
        rst                = 1'b1;
        throttle           = 1'b0;
        in_order           = 1'b1;
        input_pc_valid     = 1'b0;
        input_pc           = '0;
        input_cc_id        = '0;
        memory_ready       = 1'b1;
        memory_data        = '0;
        output_pc_ready    = 1'b1;
        current_characters = '0;
        end_of_string      = '0;
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs();
        // every opcode alone with SPLIT order included
        for (int op = 0; op < 10; op++)
            for (int rep = 0; rep < SINGLE_REPS; rep++)
                run_single(regex_pkg::opcode_t'(op), rep);
        run_stream(1'b0);
        run_stream(1'b1);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- regex_cpu.sv
// top of the regex thread processor that ties fetch, two execute stages and the output merge together
`timescale 1ns/1ps

module regex_cpu (
    input  logic                                clk,
    input  logic                                rst,

    input  regex_pkg::window_t                  current_characters,
    input  logic [regex_pkg::WINDOW_CHARS-1:0]  end_of_string,

    input  logic                                input_pc_valid,
    input  regex_pkg::pc_t                      input_pc,
    input  regex_pkg::cc_id_t                   input_cc_id,
    output logic                                input_pc_ready,

    input  logic                                memory_ready,
    output logic                                memory_valid,
    output logic [regex_pkg::ADDR_WIDTH-1:0]    memory_addr,
    input  regex_pkg::instr_t                   memory_data,

    output logic                                output_pc_valid,
    output regex_pkg::pc_t                      output_pc,
    output regex_pkg::cc_id_t                   output_cc_id,
    input  logic                                output_pc_ready,

    output logic                                accepts,
    output logic                                running
);

    logic              fetch_valid;
    regex_pkg::pc_t    fetch_pc;
    regex_pkg::cc_id_t fetch_cc_id;
    regex_pkg::instr_t fetch_instr;
    logic              fetch_ready;

    logic              exe1_out_valid;
    regex_pkg::pc_t    exe1_out_pc;
    regex_pkg::cc_id_t exe1_out_cc_id;
    logic              exe1_out_ready;
    logic              exe2_out_valid;
    regex_pkg::pc_t    exe2_out_pc;
    regex_pkg::cc_id_t exe2_out_cc_id;
    logic              exe2_out_ready;

    logic              busy;

    regex_fetch u_fetch (
        .clk            (clk),
        .rst            (rst),
        .input_pc_valid (input_pc_valid),
        .input_pc       (input_pc),
        .input_cc_id    (input_cc_id),
        .input_pc_ready (input_pc_ready),
        .memory_ready   (memory_ready),
        .memory_valid   (memory_valid),
        .memory_addr    (memory_addr),
        .memory_data    (memory_data),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_cc_id    (fetch_cc_id),
        .fetch_instr    (fetch_instr),
        .fetch_ready    (fetch_ready)
    );

    regex_execute u_execute (
        .clk                (clk),
        .rst                (rst),
        .fetch_valid        (fetch_valid),
        .fetch_pc           (fetch_pc),
        .fetch_cc_id        (fetch_cc_id),
        .fetch_instr        (fetch_instr),
        .fetch_ready        (fetch_ready),
        .current_characters (current_characters),
        .end_of_string      (end_of_string),
        .exe1_out_valid     (exe1_out_valid),
        .exe1_out_pc        (exe1_out_pc),
        .exe1_out_cc_id     (exe1_out_cc_id),
        .exe1_out_ready     (exe1_out_ready),
        .exe2_out_valid     (exe2_out_valid),
        .exe2_out_pc        (exe2_out_pc),
        .exe2_out_cc_id     (exe2_out_cc_id),
        .exe2_out_ready     (exe2_out_ready),
        .accepts            (accepts),
        .busy               (busy)
    );

    regex_pc_merge u_merge (
        .clk             (clk),
        .rst             (rst),
        .exe1_out_valid  (exe1_out_valid),
        .exe1_out_pc     (exe1_out_pc),
        .exe1_out_cc_id  (exe1_out_cc_id),
        .exe1_out_ready  (exe1_out_ready),
        .exe2_out_valid  (exe2_out_valid),
        .exe2_out_pc     (exe2_out_pc),
        .exe2_out_cc_id  (exe2_out_cc_id),
        .exe2_out_ready  (exe2_out_ready),
        .output_pc_valid (output_pc_valid),
        .output_pc       (output_pc),
        .output_cc_id    (output_cc_id),
        .output_pc_ready (output_pc_ready)
    );

    // a thread is in flight anywhere from fetch to stage 2
    assign running = fetch_valid || busy;

endmodule

//--- regex_pc_merge.sv
// round-robin merge of the two execute thread outputs onto the single output channel
`timescale 1ns/1ps

module regex_pc_merge (
    input  logic              clk,
    input  logic              rst,

    input  logic              exe1_out_valid,
    input  regex_pkg::pc_t    exe1_out_pc,
    input  regex_pkg::cc_id_t exe1_out_cc_id,
    output logic              exe1_out_ready,

    input  logic              exe2_out_valid,
    input  regex_pkg::pc_t    exe2_out_pc,
    input  regex_pkg::cc_id_t exe2_out_cc_id,
    output logic              exe2_out_ready,

    output logic              output_pc_valid,
    output regex_pkg::pc_t    output_pc,
    output regex_pkg::cc_id_t output_cc_id,
    input  logic              output_pc_ready
);

    // set when exe2 should win the next tie
    logic prio_exe2;
    logic grant_exe2;

    assign grant_exe2 = exe2_out_valid && (!exe1_out_valid || prio_exe2);

    assign output_pc_valid = exe1_out_valid || exe2_out_valid;
    assign output_pc       = grant_exe2 ? exe2_out_pc : exe1_out_pc;
    assign output_cc_id    = grant_exe2 ? exe2_out_cc_id : exe1_out_cc_id;

    assign exe1_out_ready = output_pc_ready && !grant_exe2;
    assign exe2_out_ready = output_pc_ready && grant_exe2;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prio_exe2 <= 1'b0;
        end
        else if (output_pc_valid && output_pc_ready)
        begin
            // loser of this transfer goes first next time
            prio_exe2 <= !grant_exe2;
        end
    end

endmodule

//--- regex_execute.sv
// two execute stages that run each instruction against the character window and emit continuation threads
`timescale 1ns/1ps

module regex_execute (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                fetch_valid,
    input  regex_pkg::pc_t                      fetch_pc,
    input  regex_pkg::cc_id_t                   fetch_cc_id,
    input  regex_pkg::instr_t                   fetch_instr,
    output logic                                fetch_ready,

    input  regex_pkg::window_t                  current_characters,
    input  logic [regex_pkg::WINDOW_CHARS-1:0]  end_of_string,

    output logic                                exe1_out_valid,
    output regex_pkg::pc_t                      exe1_out_pc,
    output regex_pkg::cc_id_t                   exe1_out_cc_id,
    input  logic                                exe1_out_ready,

    output logic                                exe2_out_valid,
    output regex_pkg::pc_t                      exe2_out_pc,
    output regex_pkg::cc_id_t                   exe2_out_cc_id,
    input  logic                                exe2_out_ready,

    output logic                                accepts,
    output logic                                busy
);

    logic              s1_valid;
    regex_pkg::pc_t    s1_pc;
    regex_pkg::cc_id_t s1_cc_id;
    regex_pkg::instr_t s1_instr;

    logic              s2_valid;
    regex_pkg::pc_t    s2_target;
    regex_pkg::cc_id_t s2_cc_id;

    regex_pkg::char_t    cur_char;
    regex_pkg::operand_t operand;
    logic                in_range;
    logic                s1_emits;
    logic                s1_split;
    logic                s1_leave;
    logic                s2_leave;
    regex_pkg::pc_t      s1_out_pc;
    regex_pkg::cc_id_t   s1_out_cc_id;
    logic                s1_accepts;

    assign cur_char = current_characters[s1_cc_id*regex_pkg::CHAR_WIDTH +: regex_pkg::CHAR_WIDTH];
    assign operand  = s1_instr.operand;
    assign in_range = (cur_char >= operand.chars.range_low) &&
                      (cur_char <= operand.chars.range_high);

    // stage 1 decode
    always_comb
    begin
        s1_emits     = 1'b0;
        s1_split     = 1'b0;
        s1_accepts   = 1'b0;
        s1_out_pc    = s1_pc + 1'b1;
        s1_out_cc_id = s1_cc_id + 1'b1;
        case (s1_instr.opcode)
            regex_pkg::ACCEPT:
            begin
                s1_accepts = end_of_string[s1_cc_id];
            end
            regex_pkg::ACCEPT_PARTIAL:
            begin
                s1_accepts = 1'b1;
            end
            regex_pkg::SPLIT:
            begin
                s1_emits     = 1'b1;
                s1_split     = 1'b1;
                s1_out_cc_id = s1_cc_id;
            end
            regex_pkg::MATCH:
            begin
                s1_emits = (cur_char == operand.chars.range_high);
            end
            regex_pkg::NOT_MATCH:
            begin
                s1_emits = (cur_char != operand.chars.range_high);
            end
            regex_pkg::MATCH_RANGE:
            begin
                s1_emits = in_range;
            end
            regex_pkg::NOT_MATCH_RANGE:
            begin
                s1_emits = !in_range;
            end
            regex_pkg::MATCH_ANY:
            begin
                s1_emits = 1'b1;
            end
            regex_pkg::JMP:
            begin
                s1_emits     = 1'b1;
                s1_out_pc    = operand.branch.target;
                s1_out_cc_id = s1_cc_id;
            end
            default:
            begin
                // end_without_accepting just retires
                s1_emits = 1'b0;
            end
        endcase
    end

    // a split only offers its first thread once stage 2 can take the second
    assign exe1_out_valid = s1_valid && s1_emits && (!s1_split || !s2_valid);
    assign exe1_out_pc    = s1_out_pc;
    assign exe1_out_cc_id = s1_out_cc_id;

    assign s1_leave    = s1_valid && (!s1_emits || (exe1_out_valid && exe1_out_ready));
    assign fetch_ready = !s1_valid || s1_leave;
    assign accepts     = s1_valid && s1_accepts;

    assign exe2_out_valid = s2_valid;
    assign exe2_out_pc    = s2_target;
    assign exe2_out_cc_id = s2_cc_id;
    assign s2_leave       = s2_valid && exe2_out_ready;

    assign busy = s1_valid || s2_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            if (fetch_valid && fetch_ready)
                s1_valid <= 1'b1;
            else if (s1_leave)
                s1_valid <= 1'b0;

            if (s1_leave && s1_split)
                s2_valid <= 1'b1;
            else if (s2_leave)
                s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_valid && fetch_ready)
        begin
            s1_pc    <= fetch_pc;
            s1_cc_id <= fetch_cc_id;
            s1_instr <= fetch_instr;
        end
        if (s1_leave && s1_split)
        begin
            s2_target <= operand.branch.target;
            s2_cc_id  <= s1_cc_id;
        end
    end

endmodule

//--- regex_fetch.sv
// fetch stage that issues the thread pc to instruction memory and holds the returned word for execute
`timescale 1ns/1ps

module regex_fetch (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                input_pc_valid,
    input  regex_pkg::pc_t                      input_pc,
    input  regex_pkg::cc_id_t                   input_cc_id,
    output logic                                input_pc_ready,

    input  logic                                memory_ready,
    output logic                                memory_valid,
    output logic [regex_pkg::ADDR_WIDTH-1:0]    memory_addr,
    input  regex_pkg::instr_t                   memory_data,

    output logic                                fetch_valid,
    output regex_pkg::pc_t                      fetch_pc,
    output regex_pkg::cc_id_t                   fetch_cc_id,
    output regex_pkg::instr_t                   fetch_instr,
    input  logic                                fetch_ready
);

    logic              hold_valid;
    logic              data_arrives;
    regex_pkg::pc_t    hold_pc;
    regex_pkg::cc_id_t hold_cc_id;
    regex_pkg::instr_t hold_instr;
    logic              hold_free;
    logic              fetch_take;

    assign fetch_take = fetch_valid && fetch_ready;

    // free now or the held thread moves on this cycle
    assign hold_free = !hold_valid || fetch_ready;

    assign memory_valid   = input_pc_valid && hold_free;
    assign input_pc_ready = memory_valid && memory_ready;
    assign memory_addr    = {{(regex_pkg::ADDR_WIDTH - regex_pkg::PC_WIDTH){1'b0}}, input_pc};

    assign fetch_valid = hold_valid;
    assign fetch_pc    = hold_pc;
    assign fetch_cc_id = hold_cc_id;

    // memory word is only on the bus in the cycle after the request
    assign fetch_instr = data_arrives ? memory_data : hold_instr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hold_valid   <= 1'b0;
            data_arrives <= 1'b0;
        end
        else
        begin
            data_arrives <= input_pc_ready;
            if (input_pc_ready)
            begin
                hold_valid <= 1'b1;
            end
            else if (fetch_take)
            begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (input_pc_ready)
        begin
            hold_pc    <= input_pc;
            hold_cc_id <= input_cc_id;
        end
        // keep the word around in case execute is stalled
        if (data_arrives)
        begin
            hold_instr <= memory_data;
        end
    end

endmodule

//--- regex_pkg.sv
// widths, opcodes and the instruction word layout shared by the regex thread processor and its testbench
package regex_pkg;

    localparam int PC_WIDTH     = 9;
    localparam int CC_ID_BITS   = 2;
    localparam int WINDOW_CHARS = 4;
    localparam int CHAR_WIDTH   = 8;
    localparam int OPCODE_WIDTH = 4;
    localparam int INSTR_WIDTH  = 20;
    localparam int DATA_WIDTH   = INSTR_WIDTH - OPCODE_WIDTH;
    localparam int ADDR_WIDTH   = 11;

    typedef logic [PC_WIDTH-1:0]                pc_t;
    typedef logic [CC_ID_BITS-1:0]              cc_id_t;
    typedef logic [CHAR_WIDTH-1:0]              char_t;
    // slot 0 sits in the lowest byte
    typedef logic [WINDOW_CHARS*CHAR_WIDTH-1:0] window_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        ACCEPT                = 4'd0,
        ACCEPT_PARTIAL        = 4'd1,
        SPLIT                 = 4'd2,
        MATCH                 = 4'd3,
        NOT_MATCH             = 4'd4,
        MATCH_RANGE           = 4'd5,
        NOT_MATCH_RANGE       = 4'd6,
        MATCH_ANY             = 4'd7,
        JMP                   = 4'd8,
        END_WITHOUT_ACCEPTING = 4'd9
    } opcode_t;

    // match and not_match compare against range_high alone
    typedef struct packed {
        char_t range_low;
        char_t range_high;
    } char_operand_t;

    typedef struct packed {
        logic [DATA_WIDTH-PC_WIDTH-1:0] pad;
        pc_t                            target;
    } branch_operand_t;

    typedef union packed {
        char_operand_t   chars;
        branch_operand_t branch;
    } operand_t;

    typedef struct packed {
        opcode_t  opcode;
        operand_t operand;
    } instr_t;

endpackage
